// File: Bender.yml
package:
  name: cart

sources:
  - design/cart_pkg.sv
  - design/rom_header_parser.sv
  - design/coproc_classifier.sv
  - design/save_sequencer.sv
  - design/save_byte_packer.sv
  - design/cart_top.sv
  - target: test
    files:
      - verification/cart_chk.sv
      - verification/cart_tb.sv

// File: design/cart_pkg.sv
/* Cartridge shared types and constants */

package cart_pkg;

	// ========================================
	// Widths and header layout
	// ========================================
	localparam int addr_w      = 24;
	localparam int sram_word_w = 19;
	localparam int sector_w    = 12;
	localparam int buff_addr_w = 9;

	localparam logic [addr_w-1:0] mask_base     = 24'd1024;
	localparam logic [3:0]        min_rom_shift = 4'd12;

	// Word offsets inside the header bank
	localparam logic [14:0] hdr_mapper_off  = 15'h7FD4;
	localparam logic [14:0] hdr_type_off    = 15'h7FD6;
	localparam logic [14:0] hdr_ram_off     = 15'h7FD8;
	localparam logic [14:0] hdr_company_off = 15'h7FDA;

	// ========================================
	// Encodings
	// ========================================
	typedef enum logic [1:0] {
		map_lorom   = 2'd0,
		map_hirom   = 2'd1,
		map_exhirom = 2'd2
	} map_mode_t;

	// Upper nibble of the ROM type byte
	typedef enum logic [3:0] {
		chip_none = 4'h0,
		chip_dsp1 = 4'h8,
		chip_dsp2 = 4'h9,
		chip_dsp3 = 4'hA,
		chip_dsp4 = 4'hB,
		chip_obc1 = 4'hC
	} chip_t;

	// ========================================
	// Bundles
	// ========================================
	typedef struct packed {
		logic              wr;
		logic [addr_w-1:0] addr;
		logic [15:0]       data;
	} dl_beat_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} hdr_bytes_t;

	// Size nibble and type byte of the header
	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] size;
		logic [7:0] type_id;
	} hdr_size_t;

	typedef union packed {
		hdr_bytes_t bytes;
		hdr_size_t  st;
	} hdr_word_u;

	typedef struct packed {
		logic [7:0]        rom_type;
		logic [addr_w-1:0] rom_mask;
		logic [addr_w-1:0] ram_mask;
	} cart_info_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

	typedef struct packed {
		logic [buff_addr_w-1:0] addr;
		logic [7:0]             dout;
		logic                   wr;
		logic                   rd;
	} sd_buff_t;

	typedef struct packed {
		logic [sram_word_w-1:0] addr;
		logic [15:0]            d;
		logic                   req;
		logic                   we;
	} sram_io_t;

endpackage

// File: design/cart_top.sv
/* Cartridge detection and save RAM top */

`timescale 1ns/100ps

module cart_top (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cart_pkg::dl_beat_t   dl,
	input  logic                 download,
	input  cart_pkg::map_mode_t  map_mode,
	input  logic                 img_mounted,
	input  logic [31:0]          img_size,
	input  logic                 bk_save,
	input  logic                 sd_ack,
	input  cart_pkg::sd_buff_t   sd_buff,
	input  logic [15:0]          sram_q,
	output cart_pkg::cart_info_t cart,
	output cart_pkg::sd_req_t    sd,
	output logic [7:0]           sd_buff_din,
	output cart_pkg::sram_io_t   sram,
	output logic                 bk_ena,
	output logic                 bk_load
);
	import cart_pkg::*;

	logic [23:0]       hdr_fields;
	logic [1:0]        map_bits;
	logic [addr_w-1:0] rom_mask;
	logic [addr_w-1:0] ram_mask;
	chip_t             chip;
	logic              start;
	logic              save_dir;

	// ========================================
	// Header detection
	// ========================================
	rom_header_parser u_parser (
		.clk_sys    (clk_sys),
		.dl         (dl),
		.download   (download),
		.map_mode   (map_mode),
		.hdr_fields (hdr_fields),
		.map_bits   (map_bits),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask)
	);

	coproc_classifier u_classifier (
		.clk_sys    (clk_sys),
		.dl         (dl),
		.download   (download),
		.hdr_fields (hdr_fields),
		.chip       (chip)
	);

	assign cart = '{rom_type: {chip, 2'b00, map_bits}, rom_mask: rom_mask, ram_mask: ram_mask};

	// ========================================
	// Save RAM backup
	// ========================================
	save_sequencer u_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_save     (bk_save),
		.sd_ack      (sd_ack),
		.sd          (sd),
		.bk_ena      (bk_ena),
		.bk_load     (bk_load),
		.start       (start),
		.save_dir    (save_dir)
	);

	save_byte_packer u_packer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bk_load     (bk_load),
		.start       (start),
		.save_dir    (save_dir),
		.sd_buff     (sd_buff),
		.sram_q      (sram_q),
		.sd_buff_din (sd_buff_din),
		.sram        (sram)
	);

endmodule

// File: design/coproc_classifier.sv
/* Coprocessor classification */

`timescale 1ns/100ps

module coproc_classifier (
	input  logic               clk_sys,
	input  cart_pkg::dl_beat_t dl,
	input  logic               download,
	input  logic [23:0]        hdr_fields,
	output cart_pkg::chip_t    chip
);
	import cart_pkg::*;

	logic [7:0] mapper;
	logic [7:0] rtype;
	logic [7:0] company;
	logic       is_dsp1;

	assign {mapper, rtype, company} = hdr_fields;

	// DSP1 has several mapper and type pairs
	assign is_dsp1 = ((mapper == 8'h20 || mapper == 8'h21) && rtype == 8'h03) ||
		(mapper == 8'h30 && rtype == 8'h05) ||
		(mapper == 8'h31 && (rtype == 8'h03 || rtype == 8'h05));

	always_ff @(posedge clk_sys) begin
		if (download) begin
			if (dl.wr && dl.addr == '0)
				chip <= chip_none;
		end else begin
			// DSP3 shares mapper and type with DSP1 and wins on company
			if (mapper == 8'h30 && rtype == 8'h05 && company == 8'hB2)
				chip <= chip_dsp3;
			else if (is_dsp1)
				chip <= chip_dsp1;
			else if (mapper == 8'h20 && rtype == 8'h05)
				chip <= chip_dsp2;
			else if (mapper == 8'h30 && rtype == 8'h03)
				chip <= chip_dsp4;
			else if (mapper == 8'h30 && rtype == 8'h25)
				chip <= chip_obc1;
			else
				chip <= chip_none;
		end
	end

endmodule

// File: design/rom_header_parser.sv
/* ROM header capture and size masks */

`timescale 1ns/100ps

module rom_header_parser (
	input  logic                        clk_sys,
	input  cart_pkg::dl_beat_t          dl,
	input  logic                        download,
	input  cart_pkg::map_mode_t         map_mode,
	output logic [23:0]                 hdr_fields,
	output logic [1:0]                  map_bits,
	output logic [cart_pkg::addr_w-1:0] rom_mask,
	output logic [cart_pkg::addr_w-1:0] ram_mask
);
	import cart_pkg::*;

	logic [8:0] hdr_prefix;
	logic [7:0] mapper_byte;
	logic [7:0] type_byte;
	logic [7:0] company_byte;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic [3:0] rom_shift;
	hdr_word_u  word;
	logic       beat;

	// Bank prefix of the header for each map mode
	always_comb begin
		case (map_mode)
			map_exhirom: hdr_prefix = {8'h40, 1'b1};
			map_hirom:   hdr_prefix = {8'h00, 1'b1};
			default:     hdr_prefix = 9'd0;
		endcase
	end

	assign word = dl.data;
	assign beat = download & dl.wr;

	// ========================================
	// Header field capture
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (beat) begin
			// New image starts at address 0
			if (dl.addr == '0) begin
				ram_size <= 4'd0;
				map_bits <= map_mode;
			end
			if (dl.addr == {hdr_prefix, hdr_mapper_off})
				mapper_byte <= word.bytes.hi;
			if (dl.addr == {hdr_prefix, hdr_type_off}) begin
				rom_size  <= word.st.size;
				type_byte <= word.st.type_id;
			end
			if (dl.addr == {hdr_prefix, hdr_ram_off})
				ram_size <= word.st.type_id[3:0];
			if (dl.addr == {hdr_prefix, hdr_company_off})
				company_byte <= word.bytes.lo;
		end
	end

	// Small size fields fall back to a 4 MB mask
	assign rom_shift = (rom_size < 4'd7) ? min_rom_shift : rom_size;

	always_ff @(posedge clk_sys) begin
		rom_mask <= (mask_base << rom_shift) - 1'b1;
		ram_mask <= (ram_size == 4'd0) ? '0 : (mask_base << ram_size) - 1'b1;
	end

	assign hdr_fields = {mapper_byte, type_byte, company_byte};

endmodule

// File: design/save_byte_packer.sv
/* Save RAM byte packing */

`timescale 1ns/100ps

module save_byte_packer (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               bk_load,
	input  logic               start,
	input  logic               save_dir,
	input  cart_pkg::sd_buff_t sd_buff,
	input  logic [15:0]        sram_q,
	output logic [7:0]         sd_buff_din,
	output cart_pkg::sram_io_t sram
);
	import cart_pkg::*;

	logic [sram_word_w-1:0] word_addr;
	logic [15:0]            word_d;
	logic                   req;
	logic [15:0]            q_save;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req <= 1'b0;
		end else begin
			// Save prefetches word 0 and load starts at all ones to wrap onto 0
			if (start) begin
				if (save_dir) begin
					word_addr <= '0;
					req       <= ~req;
				end else begin
					word_addr <= '1;
				end
			end

			// Load path
			if (sd_buff.wr) begin
				if (sd_buff.addr[0]) begin
					word_d[15:8] <= sd_buff.dout;
					req          <= ~req;
					word_addr    <= word_addr + 1'b1;
				end else begin
					word_d[7:0] <= sd_buff.dout;
				end
			end

			// Save path fetches the next word after the high byte goes out
			if (sd_buff.rd && sd_buff.addr[0]) begin
				req       <= ~req;
				word_addr <= word_addr + 1'b1;
			end
		end
	end

	// Hold the word steady across its odd byte
	always_ff @(posedge clk_sys) begin
		if (!sd_buff.addr[0])
			q_save <= sram_q;
	end

	assign sd_buff_din = sd_buff.addr[0] ? q_save[15:8] : q_save[7:0];

	assign sram = '{addr: word_addr, d: word_d, req: req, we: bk_load};

endmodule

// File: design/save_sequencer.sv
/* Save image sector sequencer */

`timescale 1ns/100ps

module save_sequencer (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              download,
	input  logic              img_mounted,
	input  logic [31:0]       img_size,
	input  logic              bk_save,
	input  logic              sd_ack,
	output cart_pkg::sd_req_t sd,
	output logic              bk_ena,
	output logic              bk_load,
	output logic              start,
	output logic              save_dir
);
	import cart_pkg::*;

	logic                mounted_d;
	logic                download_d;
	logic                save_d;
	logic                load_d;
	logic                ack_d;
	logic                xfer_active;
	logic [sector_w-1:0] sav_size;
	logic                load_rise;
	logic                save_rise;

	assign load_rise = bk_load & ~load_d;
	assign save_rise = bk_save & ~save_d;

	// One-cycle kick for the packer at the start of a transfer
	assign start    = ~xfer_active & bk_ena & (load_rise | save_rise);
	assign save_dir = ~bk_load;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena      <= 1'b0;
			bk_load     <= 1'b0;
			xfer_active <= 1'b0;
			sd.rd       <= 1'b0;
			sd.wr       <= 1'b0;
			mounted_d   <= 1'b0;
			download_d  <= 1'b0;
			save_d      <= 1'b0;
			load_d      <= 1'b0;
			ack_d       <= 1'b0;
		end else begin
			mounted_d  <= img_mounted;
			download_d <= download;
			save_d     <= bk_save;
			load_d     <= bk_load;
			ack_d      <= sd_ack;

			// ========================================
			// Enable and load triggers
			// ========================================
			if (img_mounted & ~mounted_d) begin
				if (|img_size) begin
					bk_ena   <= 1'b1;
					bk_load  <= 1'b1;
					sav_size <= img_size[20:9];
				end else begin
					bk_ena <= 1'b0;
				end
			end
			if (download & ~download_d)
				bk_ena <= 1'b0;

			// Host took the request
			if (sd_ack & ~ack_d) begin
				sd.rd <= 1'b0;
				sd.wr <= 1'b0;
			end

			// ========================================
			// Sector loop
			// ========================================
			if (start) begin
				xfer_active <= 1'b1;
				sd.lba      <= 32'd0;
				sd.rd       <= bk_load;
				sd.wr       <= ~bk_load;
			end else if (xfer_active && ack_d && !sd_ack) begin
				if (sd.lba[sector_w-1:0] == sav_size) begin
					bk_load     <= 1'b0;
					xfer_active <= 1'b0;
				end else begin
					sd.lba <= sd.lba + 32'd1;
					sd.rd  <= bk_load;
					sd.wr  <= ~bk_load;
				end
			end
		end
	end

endmodule

// File: verification/cart_chk.sv
/* SD and save RAM protocol checks */

`timescale 1ns/100ps

module cart_chk (
	input logic               clk_sys,
	input logic               reset,
	input logic               download,
	input logic               sd_ack,
	input logic               bk_ena,
	input cart_pkg::sd_req_t  sd,
	input cart_pkg::sram_io_t sram
);
	int failures = 0;

	// ========================================
	// SD request handshake
	// ========================================
	one_direction: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd.rd && sd.wr))
	else begin
		$error("SD read and write requested together");
		failures++;
	end

	// Host must see the request until it acknowledges
	rd_held: assert property (@(posedge clk_sys) disable iff (reset)
		(sd.rd && !sd_ack) |=> sd.rd)
	else begin
		$error("SD read request dropped before sd_ack rose");
		failures++;
	end

	wr_held: assert property (@(posedge clk_sys) disable iff (reset)
		(sd.wr && !sd_ack) |=> sd.wr)
	else begin
		$error("SD write request dropped before sd_ack rose");
		failures++;
	end

	// ========================================
	// Enable control
	// ========================================
	ena_cleared: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(download) |=> !bk_ena)
	else begin
		$error("bk_ena still high after download rose");
		failures++;
	end

	req_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		!bk_ena |=> $stable(sram.req))
	else begin
		$error("save RAM request toggled while bk_ena was low");
		failures++;
	end

endmodule

// File: verification/cart_tb.sv
/* Cartridge testbench */

`timescale 1ns/100ps

module cart_tb;
	import cart_pkg::*;

	logic        clk_sys;
	logic        reset;
	dl_beat_t    dl;
	logic        download;
	map_mode_t   map_mode;
	logic        img_mounted;
	logic [31:0] img_size;
	logic        bk_save;
	logic        sd_ack;
	sd_buff_t    sd_buff;
	logic [15:0] sram_q;
	cart_info_t  cart;
	sd_req_t     sd;
	logic [7:0]  sd_buff_din;
	sram_io_t    sram;
	logic        bk_ena;
	logic        bk_load;

	int    seed = 9;
	string cur_test;
	int    test_checks;
	int    test_errors;
	int    tests_run;
	int    tests_failed;
	int    total_checks;
	int    total_errors;

	// Save RAM model state
	logic [15:0] mem [0:1023];
	logic        req_seen;
	logic [15:0] q_next;
	logic [18:0] wr_addr_log [$];
	logic [15:0] wr_data_log [$];
	logic [7:0]  load_bytes [$];

	cart_top u_cart_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.download    (download),
		.map_mode    (map_mode),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.bk_save     (bk_save),
		.sd_ack      (sd_ack),
		.sd_buff     (sd_buff),
		.sram_q      (sram_q),
		.cart        (cart),
		.sd          (sd),
		.sd_buff_din (sd_buff_din),
		.sram        (sram),
		.bk_ena      (bk_ena),
		.bk_load     (bk_load)
	);

	bind cart_top cart_chk u_chk (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.download (download),
		.sd_ack   (sd_ack),
		.bk_ena   (bk_ena),
		.sd       (sd),
		.sram     (sram)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ========================================
	// Save RAM model with one word per request toggle
	// ========================================
	always @(negedge clk_sys) begin
		if (!reset && sram.req !== req_seen) begin
			if (sram.we) begin
				mem[sram.addr[9:0]] = sram.d;
				wr_addr_log.push_back(sram.addr);
				wr_data_log.push_back(sram.d);
			end else begin
				q_next = mem[sram.addr[9:0]];
			end
		end
		req_seen = sram.req;
	end

	always @(posedge clk_sys) begin
		#2 sram_q = q_next;
	end

	// ========================================
	// Report helpers
	// ========================================
	task automatic check_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		test_checks++;
		assert (actual === expected)
		else begin
			test_errors++;
			$display("** Error: test %s, %s: expected 'h%0h, actual 'h%0h",
				cur_test, what, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test;
		$display("Test %-10s %0d checks, %0d errors", cur_test, test_checks, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		total_checks += test_checks;
		total_errors += test_errors;
	endtask

	task automatic flag_timeout(input string why);
		test_errors++;
		$display("Timeout in test %s: %s", cur_test, why);
	endtask

	// ========================================
	// Stimulus
	// ========================================
	task automatic tick;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic send_beat(input logic [23:0] addr, input logic [15:0] data);
		tick;
		dl.wr = 1'b1;
		dl.addr = addr;
		dl.data = data;
		tick;
		dl.wr = 1'b0;
	endtask

	task automatic run_download(input map_mode_t mode, input logic [7:0] mapper,
			input logic [7:0] rtype, input logic [3:0] rom_sz, input logic [3:0] ram_sz,
			input logic [7:0] company, input logic [3:0] exp_chip,
			input logic [23:0] exp_rom, input logic [23:0] exp_ram);
		logic [23:0] base;
		logic [31:0] r;
		int          k;
		case (mode)
			map_hirom:   base = 24'h008000;
			map_exhirom: base = 24'h408000;
			default:     base = 24'h000000;
		endcase
		tick;
		map_mode = mode;
		download = 1'b1;
		r = $random(seed);
		send_beat(24'h000000, r[15:0]);
		// Filler beats stay well below any header
		for (k = 0; k < 4; k++) begin
			r = $random(seed);
			send_beat({12'h000, r[27:17], 1'b0}, r[15:0]);
		end
		r = $random(seed);
		send_beat(base + 24'h007FD4, {mapper, r[7:0]});
		send_beat(base + 24'h007FD6, {r[11:8], rom_sz, rtype});
		send_beat(base + 24'h007FD8, {r[23:12], ram_sz});
		send_beat(base + 24'h007FDA, {r[31:24], company});
		tick;
		download = 1'b0;
		// Type byte is final two cycles after download falls
		tick;
		tick;
		@(negedge clk_sys);
		check_eq("rom_type", {exp_chip, 2'b00, mode}, cart.rom_type);
		check_eq("rom_mask", exp_rom, cart.rom_mask);
		check_eq("ram_mask", exp_ram, cart.ram_mask);
	endtask

	task automatic classify_case(input map_mode_t mode, input logic [7:0] mapper,
			input logic [7:0] rtype, input logic [7:0] company, input logic [3:0] exp_chip);
		run_download(mode, mapper, rtype, 4'hA, 4'h1, company, exp_chip,
			24'h0FFFFF, 24'h0007FF);
	endtask

	task automatic mount_image(input logic [31:0] size);
		tick;
		img_size = size;
		img_mounted = 1'b1;
		tick;
		img_mounted = 1'b0;
	endtask

	task automatic pulse_save;
		tick;
		bk_save = 1'b1;
		tick;
		bk_save = 1'b0;
	endtask

	task automatic wait_request(input bit load, output bit ok);
		int   n;
		logic seen;
		n = 0;
		@(negedge clk_sys);
		seen = load ? sd.rd : sd.wr;
		while (!seen && n < 200) begin
			@(negedge clk_sys);
			seen = load ? sd.rd : sd.wr;
			n++;
		end
		ok = seen;
		if (!seen)
			flag_timeout("no SD request from the sequencer");
	endtask

	task automatic wait_load_done;
		int n;
		n = 0;
		@(negedge clk_sys);
		while (bk_load && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_load)
			flag_timeout("bk_load did not drop after the last sector");
	endtask

	// SD host model sends one byte every third cycle
	task automatic serve_transfer(input bit load, input int count);
		int          s;
		int          i;
		int          w;
		int          dly;
		logic [31:0] r;
		bit          got;
		for (s = 0; s <= count; s++) begin
			wait_request(load, got);
			if (!got)
				return;
			check_eq("lba", s, sd.lba);
			check_eq("opposite request", 0, load ? sd.wr : sd.rd);
			check_eq("bk_load", load, bk_load);
			dly = 1 + ({$random(seed)} % 6);
			repeat (dly) tick;
			sd_ack = 1'b1;
			for (i = 0; i < 512; i++) begin
				tick;
				sd_buff.wr = 1'b0;
				sd_buff.rd = 1'b0;
				sd_buff.addr = i[8:0];
				if (load) begin
					r = $random(seed);
					sd_buff.dout = r[7:0];
					load_bytes.push_back(r[7:0]);
				end
				tick;
				tick;
				if (load)
					sd_buff.wr = 1'b1;
				else
					sd_buff.rd = 1'b1;
				if (!load) begin
					@(negedge clk_sys);
					w = s * 256 + i / 2;
					check_eq("sd_buff_din", i[0] ? mem[w][15:8] : mem[w][7:0], sd_buff_din);
				end
			end
			tick;
			sd_buff.wr = 1'b0;
			sd_buff.rd = 1'b0;
			sd_ack = 1'b0;
		end
	endtask

	task automatic expect_idle(input string what);
		logic req0;
		logic sd_seen;
		logic toggled;
		int   n;
		req0 = sram.req;
		sd_seen = 1'b0;
		toggled = 1'b0;
		for (n = 0; n < 16; n++) begin
			@(negedge clk_sys);
			if (sd.rd || sd.wr)
				sd_seen = 1'b1;
			if (sram.req !== req0)
				toggled = 1'b1;
		end
		check_eq({what, " SD request"}, 0, sd_seen);
		check_eq({what, " save RAM access"}, 0, toggled);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int i;
		reset = 1'b1;
		dl = '0;
		download = 1'b0;
		map_mode = map_lorom;
		img_mounted = 1'b0;
		img_size = 32'd0;
		bk_save = 1'b0;
		sd_ack = 1'b0;
		sd_buff = '0;
		sram_q = 16'h0000;
		q_next = 16'h0000;
		req_seen = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		total_checks = 0;
		total_errors = 0;
		repeat (2) @(posedge clk_sys);
		#2 reset = 1'b0;

		begin_test("lorom");
		run_download(map_lorom, 8'h20, 8'h02, 4'd9, 4'd3, 8'h00, 4'h0, 24'h07FFFF, 24'h001FFF);
		run_download(map_lorom, 8'h20, 8'h02, 4'd5, 4'd0, 8'h00, 4'h0, 24'h3FFFFF, 24'h000000);
		end_test;

		begin_test("classify");
		classify_case(map_hirom, 8'h30, 8'h05, 8'hB2, 4'hA);
		classify_case(map_exhirom, 8'h30, 8'h05, 8'h00, 4'h8);
		classify_case(map_hirom, 8'h20, 8'h03, 8'h33, 4'h8);
		classify_case(map_exhirom, 8'h21, 8'h03, 8'h33, 4'h8);
		classify_case(map_hirom, 8'h31, 8'h03, 8'h01, 4'h8);
		classify_case(map_exhirom, 8'h31, 8'h05, 8'h01, 4'h8);
		classify_case(map_hirom, 8'h20, 8'h05, 8'hB2, 4'h9);
		classify_case(map_exhirom, 8'h30, 8'h03, 8'h01, 4'hB);
		classify_case(map_hirom, 8'h30, 8'h25, 8'h01, 4'hC);
		classify_case(map_exhirom, 8'h20, 8'h02, 8'hB2, 4'h0);
		end_test;

		begin_test("load");
		wr_addr_log.delete();
		wr_data_log.delete();
		load_bytes.delete();
		mount_image(32'd1024);
		serve_transfer(1'b1, 2);
		wait_load_done;
		check_eq("word count", 768, wr_addr_log.size());
		for (i = 0; i < wr_addr_log.size() && i < 768; i++) begin
			check_eq("word address", i, wr_addr_log[i]);
			check_eq("word data", {load_bytes[2 * i + 1], load_bytes[2 * i]}, wr_data_log[i]);
		end
		check_eq("bk_ena", 1, bk_ena);
		end_test;

		begin_test("save");
		for (i = 0; i < 1024; i++)
			mem[i] = $random(seed);
		pulse_save;
		serve_transfer(1'b0, 2);
		expect_idle("after last sector");
		check_eq("bk_load", 0, bk_load);
		end_test;

		begin_test("enable");
		check_eq("bk_ena before download", 1, bk_ena);
		run_download(map_lorom, 8'h20, 8'h02, 4'd9, 4'd3, 8'h00, 4'h0, 24'h07FFFF, 24'h001FFF);
		check_eq("bk_ena after download", 0, bk_ena);
		pulse_save;
		expect_idle("save after download");
		// One sector reload turns the enable back on
		mount_image(32'd300);
		serve_transfer(1'b1, 0);
		wait_load_done;
		check_eq("bk_ena after mount", 1, bk_ena);
		mount_image(32'd0);
		@(negedge clk_sys);
		check_eq("bk_ena after empty mount", 0, bk_ena);
		pulse_save;
		expect_idle("save after empty mount");
		end_test;

		begin_test("protocol");
		check_eq("assertion failures", 0, u_cart_top.u_chk.failures);
		end_test;

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, total_checks, total_errors);
		if (total_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog.f
design/cart_pkg.sv
design/rom_header_parser.sv
design/coproc_classifier.sv
design/save_sequencer.sv
design/save_byte_packer.sv
design/cart_top.sv
verification/cart_chk.sv
verification/cart_tb.sv
